// ==== filelist.f ====
common/encr_pkg.sv
verilog/word_fifo.sv
frame_disassembler/frame_disassembler.sv
keystream_cipher/keystream_cipher.sv
frame_reassembler/frame_reassembler.sv
verilog/encr_datapath.sv
tests/encr_datapath_assert.sv
tests/encr_datapath_tb.sv

// ==== tests/encr_datapath_tb.sv ====
/*
 * Testbench for the frame encryption datapath. A source model spends input
 * credits, a sink model returns output credits, and every delivered row is
 * compared with a reference model of the frame and keystream rules.
 */
`timescale 1ns/100ps

module encr_datapath_tb;

    localparam logic [encr_pkg::NB_KEY - 1 : 0] KEY = 128'h0f1e2d3c4b5a6978_8796a5b4c3d2e1f0;
    localparam logic [encr_pkg::NB_IV - 1 : 0]  IV  = 96'hcafe01234567_89abcdef0011;
    localparam int OVERRUN_ROWS   = 3;
    // Upper bound on rows over all tests, and cycles one row may take
    localparam int MAX_ROWS       = 100;
    localparam int CYCLES_PER_ROW = 16;
    localparam int TIMEOUT_CYCLES = MAX_ROWS * CYCLES_PER_ROW + 400;

    logic                                 i_clock;
    logic                                 i_reset;
    encr_pkg::data_row_t                  i_data;
    logic                                 i_valid;
    logic                                 i_sof;
    logic [encr_pkg::NB_KEY - 1 : 0]      i_key;
    logic [encr_pkg::NB_IV - 1 : 0]       i_iv;
    logic                                 i_bypass;
    logic                                 i_out_credit;
    logic                                 o_in_credit;
    encr_pkg::data_row_t                  o_data;
    logic                                 o_valid;
    logic                                 o_sof;
    logic [encr_pkg::NB_STAT - 1 : 0]     o_overflow_count;
    logic [encr_pkg::NB_STAT - 1 : 0]     o_resync_count;

    integer                               seed = 32'he6fe;
    encr_pkg::tagged_row_t                expected_q [$];
    int                                   in_credits = encr_pkg::IN_FIFO_DEPTH;
    int                                   sink_owed;
    bit                                   sink_random;
    bit                                   sink_hold;
    bit                                   credit_next;
    bit                                   bypass_on;
    int                                   beats_total;
    int                                   credits_granted;
    int                                   cycle_count;
    int                                   error_count;
    int                                   checks_done;
    int                                   tests_run;
    int                                   errors_at_start;

    // Reference model state
    logic [encr_pkg::NB_ROW_COUNT - 1 : 0] m_row_count;
    bit                                   m_in_frame;
    bit                                   m_payload_seen;
    logic [encr_pkg::NB_STAT - 1 : 0]     m_resync;
    logic [encr_pkg::NB_STAT - 1 : 0]     m_overflow;
    logic [encr_pkg::NB_STAT - 1 : 0]     resync_before;

    encr_datapath u_encr_datapath
    (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_data           (i_data),
        .i_valid          (i_valid),
        .i_sof            (i_sof),
        .i_key            (i_key),
        .i_iv             (i_iv),
        .i_bypass         (i_bypass),
        .i_out_credit     (i_out_credit),
        .o_in_credit      (o_in_credit),
        .o_data           (o_data),
        .o_valid          (o_valid),
        .o_sof            (o_sof),
        .o_overflow_count (o_overflow_count),
        .o_resync_count   (o_resync_count)
    );

    bind encr_datapath encr_datapath_assert u_encr_datapath_assert
    (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_out_credit (i_out_credit),
        .o_valid      (o_valid),
        .o_in_credit  (o_in_credit)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #20 i_clock = ~i_clock;
    end

    // **************************************************
    // Reference model
    // **************************************************
    function automatic encr_pkg::data_row_t keystream_ref
    (
        input logic [encr_pkg::NB_KEY - 1 : 0]       key,
        input logic [encr_pkg::NB_IV - 1 : 0]        iv,
        input logic [encr_pkg::NB_ROW_COUNT - 1 : 0] n
    );
        encr_pkg::data_row_t s;
        s = {iv, n} ^ key;
        s = s + {s[encr_pkg::NB_DATA - 1 - encr_pkg::ROT_A : 0],
                 s[encr_pkg::NB_DATA - 1 : encr_pkg::NB_DATA - encr_pkg::ROT_A]};
        return s ^ key ^ {s[encr_pkg::NB_DATA - 1 - encr_pkg::ROT_B : 0],
                          s[encr_pkg::NB_DATA - 1 : encr_pkg::NB_DATA - encr_pkg::ROT_B]};
    endfunction

    task automatic model_row(input encr_pkg::data_row_t row, input logic sof);
        encr_pkg::data_row_t exp_data;
        if (sof)
        begin
            // Header in clear, counter restarts
            exp_data = row;
            if (m_payload_seen)
                m_resync = m_resync + 1'b1;
            m_row_count    = 1;
            m_in_frame     = 1'b1;
            m_payload_seen = 1'b0;
        end
        else
        begin
            exp_data = bypass_on ? row : (row ^ keystream_ref(KEY, IV, m_row_count));
            if (m_in_frame)
            begin
                m_row_count    = m_row_count + 1'b1;
                m_payload_seen = 1'b1;
            end
        end
        expected_q.push_back({sof, exp_data});
    endtask

    // **************************************************
    // Checks and reporting
    // **************************************************
    task automatic report_error(input string msg);
        error_count = error_count + 1;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_row(input string name, input encr_pkg::data_row_t got,
                             input encr_pkg::data_row_t exp);
        checks_done = checks_done + 1;
        if (got !== exp)
        begin
            error_count = error_count + 1;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks_done = checks_done + 1;
        if (got !== exp)
        begin
            error_count = error_count + 1;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [encr_pkg::NB_STAT - 1 : 0] got,
                               input logic [encr_pkg::NB_STAT - 1 : 0] exp);
        checks_done = checks_done + 1;
        if (got !== exp)
        begin
            error_count = error_count + 1;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input int num, input string name);
        tests_run = tests_run + 1;
        if (error_count == errors_at_start)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    // **************************************************
    // Source side
    // **************************************************
    function automatic encr_pkg::data_row_t random_row();
        encr_pkg::data_row_t row;
        row[31 : 0]   = $random(seed);
        row[63 : 32]  = $random(seed);
        row[95 : 64]  = $random(seed);
        row[127 : 96] = $random(seed);
        return row;
    endfunction

    // Overrun rows ignore the credit count and are not modeled
    task automatic send_row(input encr_pkg::data_row_t row, input logic sof, input bit overrun);
        @(posedge i_clock);
        while (in_credits == 0 && !overrun)
        begin
            i_valid <= 1'b0;
            @(posedge i_clock);
        end
        i_valid <= 1'b1;
        i_data  <= row;
        i_sof   <= sof;
        if (in_credits > 0)
            in_credits = in_credits - 1;
        if (!overrun)
            model_row(row, sof);
    endtask

    task automatic send_frame(input int n_payload);
        send_row(random_row(), 1'b1, 1'b0);
        repeat (n_payload)
            send_row(random_row(), 1'b0, 1'b0);
    endtask

    task automatic idle(input int cycles);
        @(posedge i_clock);
        i_valid <= 1'b0;
        repeat (cycles - 1)
            @(posedge i_clock);
    endtask

    task automatic wait_drain();
        idle(1);
        while (expected_q.size() != 0 || sink_owed != 0)
            @(posedge i_clock);
        repeat (4)
            @(posedge i_clock);
        if (in_credits != encr_pkg::IN_FIFO_DEPTH)
            report_error("source credits were not all returned");
    endtask

    task automatic check_counters();
        @(negedge i_clock);
        check_count("o_resync_count", o_resync_count, m_resync);
        check_count("o_overflow_count", o_overflow_count, m_overflow);
    endtask

    // **************************************************
    // Sink side and output compare
    // **************************************************
    always @(negedge i_clock)
    begin : compare_outputs
        encr_pkg::tagged_row_t expected;
        credit_next = 1'b0;
        if (!i_reset)
        begin
            if (o_in_credit)
                in_credits = in_credits + 1;
            if (o_valid)
            begin
                beats_total = beats_total + 1;
                if (beats_total > encr_pkg::OUT_CREDITS_INIT + credits_granted)
                    report_error("output beat sent without an output credit held");
                if (expected_q.size() == 0)
                    report_error("output beat arrived with no row expected");
                else
                begin
                    expected = expected_q.pop_front();
                    check_row("o_data", o_data, expected[encr_pkg::NB_DATA - 1 : 0]);
                    check_flag("o_sof", o_sof, expected[encr_pkg::SOF_BIT]);
                end
                sink_owed = sink_owed + 1;
            end
            if (i_out_credit)
                credits_granted = credits_granted + 1;
            // Random return gives about one credit every other cycle
            if (sink_owed > 0 && !sink_hold && (!sink_random || (($random(seed) & 1) == 0)))
            begin
                credit_next = 1'b1;
                sink_owed   = sink_owed - 1;
            end
        end
    end

    always @(posedge i_clock)
    begin
        if (i_reset)
            i_out_credit <= 1'b0;
        else
            i_out_credit <= credit_next;
    end

    always @(posedge i_clock)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // **************************************************
    // Test sequence
    // **************************************************
    initial
    begin
        i_reset      = 1'b1;
        i_data       = '0;
        i_valid      = 1'b0;
        i_sof        = 1'b0;
        i_key        = KEY;
        i_iv         = IV;
        i_bypass     = 1'b0;
        i_out_credit = 1'b0;
        m_row_count  = '0;
        m_resync     = '0;
        m_overflow   = '0;
        repeat (3)
            @(posedge i_clock);
        i_reset <= 1'b0;

        send_frame(5);
        send_frame(3);
        wait_drain();
        check_counters();
        end_test(1, "encrypted frames");

        @(posedge i_clock);
        i_bypass <= 1'b1;
        bypass_on = 1'b1;
        send_frame(6);
        wait_drain();
        check_counters();
        @(posedge i_clock);
        i_bypass <= 1'b0;
        bypass_on = 1'b0;
        end_test(2, "bypass");

        sink_random = 1'b1;
        repeat (3)
            send_frame(3 + ($random(seed) & 7));
        wait_drain();
        check_counters();
        sink_random = 1'b0;
        end_test(3, "back-pressure");

        send_frame(3);
        wait_drain();
        resync_before = m_resync;
        // Second header lands while the first frame is still open
        send_frame(4);
        wait_drain();
        check_counters();
        check_count("o_resync_count", o_resync_count, resync_before + 1'b1);
        end_test(4, "resync");

        sink_hold = 1'b1;
        send_row(random_row(), 1'b1, 1'b0);
        do
        begin
            while (in_credits > 0)
                send_row(random_row(), 1'b0, 1'b0);
            idle(10);
        end
        while (in_credits > 0);
        repeat (OVERRUN_ROWS)
            send_row(random_row(), 1'b0, 1'b1);
        m_overflow = m_overflow + OVERRUN_ROWS;
        idle(4);
        check_counters();
        sink_hold = 1'b0;
        wait_drain();
        check_counters();
        end_test(5, "overflow");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks_done, error_count);
        if (error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== tests/encr_datapath_assert.sv ====
/*
 * Bound checks on the output credit rule and the quiet state after reset
 * of the datapath top level. Attached to the DUT with bind.
 */
`timescale 1ns/100ps

module encr_datapath_assert
(
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_valid,
    input  logic i_out_credit,
    input  logic o_valid,
    input  logic o_in_credit
);
    logic [encr_pkg::NB_OUT_CREDIT - 1 : 0] credit_count;
    logic                                   activity_seen;

    // Credits the DUT holds, seen from outside
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            credit_count  <= encr_pkg::NB_OUT_CREDIT'(encr_pkg::OUT_CREDITS_INIT);
            activity_seen <= 1'b0;
        end
        else
        begin
            credit_count <= credit_count + encr_pkg::NB_OUT_CREDIT'(i_out_credit)
                            - encr_pkg::NB_OUT_CREDIT'(o_valid);
            if (i_valid || i_out_credit)
                activity_seen <= 1'b1;
        end
    end

    credit_held: assert property (@(posedge i_clock) disable iff (i_reset)
        o_valid |-> (credit_count != '0))
        else $error("o_valid raised with no output credit held");

    quiet_after_reset: assert property (@(posedge i_clock) disable iff (i_reset)
        !activity_seen |-> (!o_valid && !o_in_credit))
        else $error("output activity before any input activity");

endmodule

// ==== verilog/encr_datapath.sv ====
/*
 * Top level of the frame encryption datapath. Splits frames into header and
 * payload, ciphers the payload in counter mode and rebuilds the frames.
 * Both the input and the output side use credit-based flow control.
 */
`timescale 1ns/100ps

module encr_datapath
(
    input  logic                                 i_clock,
    input  logic                                 i_reset,
    input  encr_pkg::data_row_t                  i_data,
    input  logic                                 i_valid,
    input  logic                                 i_sof,
    input  logic [encr_pkg::NB_KEY - 1 : 0]      i_key,
    input  logic [encr_pkg::NB_IV - 1 : 0]       i_iv,
    input  logic                                 i_bypass,
    input  logic                                 i_out_credit,
    output logic                                 o_in_credit,
    output encr_pkg::data_row_t                  o_data,
    output logic                                 o_valid,
    output logic                                 o_sof,
    output logic [encr_pkg::NB_STAT - 1 : 0]     o_overflow_count,
    output logic [encr_pkg::NB_STAT - 1 : 0]     o_resync_count
);
    // Disassembler to cipher
    encr_pkg::data_row_t                         dis_row;
    logic                                        dis_row_valid;
    logic                                        dis_row_is_header;
    logic [encr_pkg::NB_ROW_COUNT - 1 : 0]       dis_row_count;

    // Cipher to reassembler
    encr_pkg::data_row_t                         ciph_row;
    logic                                        ciph_row_valid;
    logic                                        ciph_row_is_header;

    // Back-pressure from the output buffer
    logic                                        reasm_ready;

    frame_disassembler u_frame_disassembler
    (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_data           (i_data),
        .i_valid          (i_valid),
        .i_sof            (i_sof),
        .i_ready          (reasm_ready),
        .o_in_credit      (o_in_credit),
        .o_row            (dis_row),
        .o_row_valid      (dis_row_valid),
        .o_row_is_header  (dis_row_is_header),
        .o_row_count      (dis_row_count),
        .o_overflow_count (o_overflow_count),
        .o_resync_count   (o_resync_count)
    );

    keystream_cipher u_keystream_cipher
    (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_key           (i_key),
        .i_iv            (i_iv),
        .i_bypass        (i_bypass),
        .i_row           (dis_row),
        .i_row_valid     (dis_row_valid),
        .i_row_is_header (dis_row_is_header),
        .i_row_count     (dis_row_count),
        .o_row           (ciph_row),
        .o_row_valid     (ciph_row_valid),
        .o_row_is_header (ciph_row_is_header)
    );

    frame_reassembler u_frame_reassembler
    (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_row           (ciph_row),
        .i_row_valid     (ciph_row_valid),
        .i_row_is_header (ciph_row_is_header),
        .i_out_credit    (i_out_credit),
        .o_ready         (reasm_ready),
        .o_data          (o_data),
        .o_valid         (o_valid),
        .o_sof           (o_sof)
    );

endmodule

// ==== frame_reassembler/frame_reassembler.sv ====
/*
 * Output side of the datapath. Queues ciphered rows with their header flag,
 * so each header stays ahead of its payload, and sends the head row while
 * output credits are held. Raises back-pressure before the buffer can fill.
 */
`timescale 1ns/100ps

module frame_reassembler
(
    input  logic                                 i_clock,
    input  logic                                 i_reset,
    input  encr_pkg::data_row_t                  i_row,
    input  logic                                 i_row_valid,
    input  logic                                 i_row_is_header,
    input  logic                                 i_out_credit,
    output logic                                 o_ready,
    output encr_pkg::data_row_t                  o_data,
    output logic                                 o_valid,
    output logic                                 o_sof
);
    localparam int NB_FREE = $clog2(encr_pkg::OUT_FIFO_DEPTH + 1);

    encr_pkg::tagged_row_t                       push_item;
    encr_pkg::tagged_row_t                       head_item;
    logic                                        fifo_empty;
    logic [NB_FREE - 1 : 0]                      fifo_free;
    logic [encr_pkg::NB_OUT_CREDIT - 1 : 0]      credits;
    logic                                        emit;

    // The header flag becomes start of frame on the way out
    assign push_item = {i_row_is_header, i_row};

    word_fifo
    #(
        .item_t (encr_pkg::tagged_row_t),
        .DEPTH  (encr_pkg::OUT_FIFO_DEPTH)
    )
    u_out_fifo
    (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_push      (i_row_valid),
        .i_push_item (push_item),
        .i_pop       (emit),
        .o_pop_item  (head_item),
        .o_empty     (fifo_empty),
        .o_full      (),
        .o_free      (fifo_free)
    );

    // **************************************************
    // Output credits
    // **************************************************
    assign emit = !fifo_empty && (credits != '0);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            credits <= encr_pkg::NB_OUT_CREDIT'(encr_pkg::OUT_CREDITS_INIT);
        end
        else
        begin
            case ({emit, i_out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // **************************************************
    // Output row and back-pressure
    // **************************************************
    assign o_valid = emit;
    assign o_data  = head_item[encr_pkg::NB_DATA - 1 : 0];
    assign o_sof   = emit && head_item[encr_pkg::SOF_BIT];

    // Keep room for every row that can still be in flight upstream
    assign o_ready = (fifo_free > NB_FREE'(encr_pkg::IN_FLIGHT_MAX));

endmodule

// ==== keystream_cipher/keystream_cipher.sv ====
/*
 * Counter-mode payload cipher. A three-stage pipeline derives a keystream
 * word from key, IV and row counter; payload rows are XORed with it and
 * header rows pass in clear. Fixed latency of three cycles, no stalls.
 */
`timescale 1ns/100ps

module keystream_cipher
(
    input  logic                                 i_clock,
    input  logic                                 i_reset,
    input  logic [encr_pkg::NB_KEY - 1 : 0]      i_key,
    input  logic [encr_pkg::NB_IV - 1 : 0]       i_iv,
    input  logic                                 i_bypass,
    input  encr_pkg::data_row_t                  i_row,
    input  logic                                 i_row_valid,
    input  logic                                 i_row_is_header,
    input  logic [encr_pkg::NB_ROW_COUNT - 1 : 0] i_row_count,
    output encr_pkg::data_row_t                  o_row,
    output logic                                 o_row_valid,
    output logic                                 o_row_is_header
);
    // Keystream state of each stage
    encr_pkg::data_row_t                         s1_state;
    encr_pkg::data_row_t                         s2_state;
    encr_pkg::data_row_t                         s3_keystream;

    // Row, valid and header flag travelling alongside
    encr_pkg::data_row_t                         s1_row;
    encr_pkg::data_row_t                         s2_row;
    encr_pkg::data_row_t                         s3_row;
    logic                                        s1_valid;
    logic                                        s2_valid;
    logic                                        s3_valid;
    logic                                        s1_header;
    logic                                        s2_header;
    logic                                        s3_header;

    encr_pkg::data_row_t                         counter_block;

    function automatic encr_pkg::data_row_t rotl
    (
        input encr_pkg::data_row_t value,
        input int                  amount
    );
        rotl = (value << amount) | (value >> (encr_pkg::NB_DATA - amount));
    endfunction

    assign counter_block = {i_iv, i_row_count};

    // **************************************************
    // Keystream rounds
    // **************************************************
    always_ff @(posedge i_clock)
    begin
        // Stage 1: whiten the counter block with the key
        s1_state     <= counter_block ^ i_key;
        // Stage 2: add the rotated state, modulo 2^128
        s2_state     <= s1_state + rotl(s1_state, encr_pkg::ROT_A);
        // Stage 3: mix again and fold the key back in
        s3_keystream <= s2_state ^ rotl(s2_state, encr_pkg::ROT_B) ^ i_key;

        s1_row <= i_row;
        s2_row <= s1_row;
        s3_row <= s2_row;
    end

    // Control pipe
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            s3_valid  <= 1'b0;
            s1_header <= 1'b0;
            s2_header <= 1'b0;
            s3_header <= 1'b0;
        end
        else
        begin
            s1_valid  <= i_row_valid;
            s2_valid  <= s1_valid;
            s3_valid  <= s2_valid;
            s1_header <= i_row_is_header;
            s2_header <= s1_header;
            s3_header <= s2_header;
        end
    end

    // Headers and bypassed rows leave untouched
    assign o_row           = (s3_header || i_bypass) ? s3_row : (s3_row ^ s3_keystream);
    assign o_row_valid     = s3_valid;
    assign o_row_is_header = s3_header;

endmodule

// ==== frame_disassembler/frame_disassembler.sv ====
/*
 * Input side of the datapath. Buffers incoming rows against the source
 * credits, splits each frame into header and payload rows and numbers the
 * payload rows for the keystream. Counts resyncs and input overflows.
 */
`timescale 1ns/100ps

module frame_disassembler
(
    input  logic                                 i_clock,
    input  logic                                 i_reset,
    input  encr_pkg::data_row_t                  i_data,
    input  logic                                 i_valid,
    input  logic                                 i_sof,
    input  logic                                 i_ready,
    output logic                                 o_in_credit,
    output encr_pkg::data_row_t                  o_row,
    output logic                                 o_row_valid,
    output logic                                 o_row_is_header,
    output logic [encr_pkg::NB_ROW_COUNT - 1 : 0] o_row_count,
    output logic [encr_pkg::NB_STAT - 1 : 0]     o_overflow_count,
    output logic [encr_pkg::NB_STAT - 1 : 0]     o_resync_count
);
    encr_pkg::tagged_row_t                       push_item;
    encr_pkg::tagged_row_t                       head_item;
    logic                                        fifo_empty;
    logic                                        fifo_full;
    logic                                        pop;
    logic                                        popped;
    logic                                        head_is_header;
    logic                                        in_frame;
    logic                                        payload_seen;
    logic [encr_pkg::NB_ROW_COUNT - 1 : 0]       row_count;

    assign push_item      = {i_sof, i_data};
    assign pop            = i_ready && !fifo_empty;
    assign head_is_header = head_item[encr_pkg::SOF_BIT];

    // One credit goes back for every row that leaves the buffer
    assign o_in_credit = popped;
    assign o_row_valid = popped;

    word_fifo
    #(
        .item_t (encr_pkg::tagged_row_t),
        .DEPTH  (encr_pkg::IN_FIFO_DEPTH)
    )
    u_in_fifo
    (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_push      (i_valid),
        .i_push_item (push_item),
        .i_pop       (pop),
        .o_pop_item  (head_item),
        .o_empty     (fifo_empty),
        .o_full      (fifo_full),
        .o_free      ()
    );

    // Output row register
    always_ff @(posedge i_clock)
    begin
        if (pop)
        begin
            o_row           <= head_item[encr_pkg::NB_DATA - 1 : 0];
            o_row_is_header <= head_is_header;
            o_row_count     <= head_is_header ? '0 : row_count;
        end
    end

    // **************************************************
    // Frame tracking and statistics
    // **************************************************
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            popped           <= 1'b0;
            in_frame         <= 1'b0;
            payload_seen     <= 1'b0;
            row_count        <= '0;
            o_overflow_count <= '0;
            o_resync_count   <= '0;
        end
        else
        begin
            popped <= pop;
            // Source overran its credits, row is lost
            if (i_valid && fifo_full)
                o_overflow_count <= o_overflow_count + 1'b1;
            if (pop)
            begin
                if (head_is_header)
                begin
                    // New header restarts the keystream counter
                    row_count    <= encr_pkg::NB_ROW_COUNT'(1);
                    in_frame     <= 1'b1;
                    payload_seen <= 1'b0;
                    if (payload_seen)
                        o_resync_count <= o_resync_count + 1'b1;
                end
                else if (in_frame)
                begin
                    row_count    <= row_count + 1'b1;
                    payload_seen <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/word_fifo.sv ====
/*
 * Synchronous circular FIFO for any packed payload type. The head item is
 * shown combinationally; a push when full and a pop when empty are ignored.
 */
`timescale 1ns/100ps

module word_fifo
#(
    parameter type item_t = logic,
    parameter int  DEPTH  = 8
)
(
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  logic                            i_push,
    input  item_t                           i_push_item,
    input  logic                            i_pop,
    output item_t                           o_pop_item,
    output logic                            o_empty,
    output logic                            o_full,
    output logic [$clog2(DEPTH + 1) - 1 : 0] o_free
);
    localparam int NB_PTR   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int NB_COUNT = $clog2(DEPTH + 1);

    item_t                  mem [DEPTH];
    logic [NB_PTR - 1 : 0]  wr_ptr;
    logic [NB_PTR - 1 : 0]  rd_ptr;
    logic [NB_COUNT - 1 : 0] count;
    logic                   push_ok;
    logic                   pop_ok;

    assign push_ok    = i_push && !o_full;
    assign pop_ok     = i_pop && !o_empty;
    assign o_empty    = (count == '0);
    assign o_full     = (count == NB_COUNT'(DEPTH));
    assign o_free     = NB_COUNT'(DEPTH) - count;
    assign o_pop_item = mem[rd_ptr];

    // Storage
    always_ff @(posedge i_clock)
    begin
        if (push_ok)
            mem[wr_ptr] <= i_push_item;
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= (wr_ptr == NB_PTR'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= (rd_ptr == NB_PTR'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push_ok && !pop_ok)
                count <= count + 1'b1;
            else if (pop_ok && !push_ok)
                count <= count - 1'b1;
        end
    end

endmodule

// ==== common/encr_pkg.sv ====
/*
 * Shared widths, frame constants, credit constants and row types of the
 * frame encryption datapath. Every user refers to them as encr_pkg::name.
 */
package encr_pkg;

    // **************************************************
    // Datapath widths
    // **************************************************
    localparam int NB_DATA      = 128;
    localparam int NB_KEY       = 128;
    localparam int NB_IV        = 96;
    // IV followed by the row counter forms the 128-bit counter block
    localparam int NB_ROW_COUNT = 32;
    localparam int NB_STAT      = 16;

    // **************************************************
    // Buffers and credits
    // **************************************************
    // Input buffer depth, also the source credits after reset
    localparam int IN_FIFO_DEPTH    = 8;
    localparam int OUT_FIFO_DEPTH   = 8;

    // Output credits held after reset
    localparam int OUT_CREDITS_INIT = 4;
    localparam int NB_OUT_CREDIT    = 4;

    // Rows that may still land in the output buffer after ready drops:
    // one in the disassembler register and three in the cipher
    localparam int IN_FLIGHT_MAX    = 4;

    // **************************************************
    // Keystream round rotations
    // **************************************************
    localparam int ROT_A = 29;
    localparam int ROT_B = 71;

    // **************************************************
    // Row types
    // **************************************************
    // Position of the start-of-frame flag in a tagged row
    localparam int SOF_BIT = NB_DATA;

    typedef logic [NB_DATA - 1 : 0] data_row_t;

    // Start-of-frame flag on top of the data row
    typedef logic [NB_DATA : 0]     tagged_row_t;

endpackage
